/* source/rv32i_types.sv */
package rv32i_types;

    // ########################################################################
    // Address split of a 32-byte cache line.
    // ########################################################################
    localparam int line_off_w = 5;    // Byte offset within a line.
    localparam int line_tag_w = 27;   // Line address, bits 31 down to 5.

    // ########################################################################
    // Memory port opcode.
    // ########################################################################
    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    // ########################################################################
    // FSM state encodings.
    // ########################################################################
    typedef enum logic [1:0] {
        DR_IDLE,
        DR_REQ,
        DR_RELEASE
    } drain_state_t;

    typedef enum logic [2:0] {
        FE_IDLE,
        FE_LOOKUP,
        FE_MEM_REQ,
        FE_MEM_RELEASE,
        FE_ACK,
        FE_WAIT_DROP
    } fetch_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DRAIN,
        ARB_FETCH,
        ARB_RELEASE
    } arb_state_t;

endpackage

/* source/ewb.sv */
`timescale 1ns/1ps

module ewb
    import rv32i_types::*;
#(
    parameter int width = 256,
    parameter int cap   = 64
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Eviction input, accepted when valid and not full.
    input  logic [width-1:0]      data_i,
    input  logic [31:0]           addr_i,
    input  logic                  valid_i,
    output logic                  full_o,

    // Associative line lookup.
    input  logic                  tag_check_i,
    input  logic [line_tag_w-1:0] tag_i,
    output logic                  hit_o,
    output logic [width-1:0]      read_o,

    // Head of the queue, valid-yumi.
    output logic                  empty_o,
    output logic [31:0]           addr_o,
    output logic [width-1:0]      data_o,
    input  logic                  yumi_i
);

    localparam int idx_w = $clog2(cap);

    // ########################################################################
    // Storage and pointers.
    // ########################################################################
    logic [width-1:0] q_data [cap];
    logic [31:0]      q_addr [cap];

    logic [idx_w-1:0] rd_ptr;
    logic [idx_w-1:0] wr_ptr;
    logic [idx_w-1:0] rd_ptr_nxt;
    logic [idx_w-1:0] wr_ptr_nxt;
    logic [idx_w:0]   count;

    logic enqueue;
    logic dequeue;

    assign rd_ptr_nxt = (rd_ptr == idx_w'(cap - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_nxt = (wr_ptr == idx_w'(cap - 1)) ? '0 : wr_ptr + 1'b1;

    assign full_o  = (count == (idx_w + 1)'(cap));
    assign empty_o = (count == '0);
    assign enqueue = valid_i && !full_o;
    assign dequeue = yumi_i && !empty_o;

    // Oldest entry goes out to the drain engine.
    assign addr_o = q_addr[rd_ptr];
    assign data_o = q_data[rd_ptr];

    // ########################################################################
    // Pointer and occupancy update.
    // ########################################################################
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr_nxt;
            end
            case ({enqueue, dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither.
            endcase
        end
    end

    // Entry payload, written at the tail.
    always_ff @(posedge clk) begin
        if (enqueue) begin
            q_data[wr_ptr] <= data_i;
            q_addr[wr_ptr] <= addr_i;
        end
    end

    // ########################################################################
    // Lookup scan, oldest to newest so the newest match wins.
    // ########################################################################
    always_comb begin
        int pos;
        hit_o  = 1'b0;
        read_o = '0;
        pos    = 0;
        if (tag_check_i) begin
            for (int i = 0; i < cap; i++) begin
                pos = int'(rd_ptr) + i;
                if (pos >= cap) begin
                    pos = pos - cap;              // Wrap around the ring.
                end
                if ((i < int'(count)) &&
                    (q_addr[pos[idx_w-1:0]][31:line_off_w] == tag_i)) begin
                    hit_o  = 1'b1;
                    read_o = q_data[pos[idx_w-1:0]];
                end
            end
        end
    end

endmodule : ewb

/* source/ewb_drain.sv */
`timescale 1ns/1ps

module ewb_drain
    import rv32i_types::*;
#(
    parameter int width = 256
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Buffer head.
    input  logic                  empty_i,
    input  logic [31:0]           head_addr_i,
    input  logic [width-1:0]      head_data_i,
    output logic                  yumi_o,

    // Write client towards the arbiter.
    output logic                  wr_req_o,
    output logic [line_tag_w-1:0] wr_addr_o,
    output logic [width-1:0]      wr_data_o,
    input  logic                  wr_ack_i
);

    drain_state_t state;

    logic [line_tag_w-1:0] addr_q;
    logic [width-1:0]      data_q;

    // ########################################################################
    // Drain FSM.
    // ########################################################################
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= DR_IDLE;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (!empty_i) state <= DR_REQ;
                end
                DR_REQ: begin
                    if (wr_ack_i) state <= DR_RELEASE;
                end
                DR_RELEASE: begin
                    if (!wr_ack_i) state <= DR_IDLE;   // Entry retires here.
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // Head copy, held through the whole write.
    always_ff @(posedge clk) begin
        if (state == DR_IDLE && !empty_i) begin
            addr_q <= head_addr_i[31:line_off_w];
            data_q <= head_data_i;
        end
    end

    assign wr_req_o  = (state == DR_REQ);
    assign wr_addr_o = addr_q;
    assign wr_data_o = data_q;

    // Retire only once memory holds the line.
    assign yumi_o = (state == DR_RELEASE) && !wr_ack_i;

endmodule : ewb_drain

/* source/line_fetch.sv */
`timescale 1ns/1ps

module line_fetch
    import rv32i_types::*;
#(
    parameter int width = 256
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Refill port from the cache.
    input  logic                  fill_req_i,
    input  logic [31:0]           fill_addr_i,
    output logic                  fill_ack_o,
    output logic [width-1:0]      fill_data_o,

    // Buffer probe.
    output logic                  tag_check_o,
    output logic [line_tag_w-1:0] tag_o,
    input  logic                  hit_i,
    input  logic [width-1:0]      hit_data_i,

    // Read client towards the arbiter.
    output logic                  rd_req_o,
    output logic [line_tag_w-1:0] rd_addr_o,
    input  logic                  rd_ack_i,
    input  logic [width-1:0]      rd_data_i
);

    fetch_state_t state;

    logic [width-1:0] line_q;

    // Address is held stable by the requester for the whole request.
    assign tag_o     = fill_addr_i[31:line_off_w];
    assign rd_addr_o = fill_addr_i[31:line_off_w];

    assign tag_check_o = (state == FE_LOOKUP);   // One probe per request.
    assign rd_req_o    = (state == FE_MEM_REQ);
    assign fill_ack_o  = (state == FE_WAIT_DROP);
    assign fill_data_o = line_q;

    // ########################################################################
    // Fetch FSM.
    // ########################################################################
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= FE_IDLE;
        end else begin
            case (state)
                FE_IDLE: begin
                    if (fill_req_i) state <= FE_LOOKUP;
                end
                FE_LOOKUP: begin
                    state <= hit_i ? FE_ACK : FE_MEM_REQ;
                end
                FE_MEM_REQ: begin
                    if (rd_ack_i) state <= FE_MEM_RELEASE;
                end
                FE_MEM_RELEASE: begin
                    if (!rd_ack_i) state <= FE_ACK;
                end
                FE_ACK: begin
                    state <= FE_WAIT_DROP;       // Ack goes high next cycle.
                end
                FE_WAIT_DROP: begin
                    if (!fill_req_i) state <= FE_IDLE;
                end
                default: state <= FE_IDLE;
            endcase
        end
    end

    // Line capture from whichever source answered.
    always_ff @(posedge clk) begin
        if (state == FE_LOOKUP && hit_i) begin
            line_q <= hit_data_i;
        end else if (state == FE_MEM_REQ && rd_ack_i) begin
            line_q <= rd_data_i;
        end
    end

endmodule : line_fetch

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import rv32i_types::*;
#(
    parameter int width = 256
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Drain client, writes.
    input  logic                  dr_req_i,
    input  logic [line_tag_w-1:0] dr_addr_i,
    input  logic [width-1:0]      dr_data_i,
    output logic                  dr_ack_o,

    // Fetch client, reads.
    input  logic                  fe_req_i,
    input  logic [line_tag_w-1:0] fe_addr_i,
    output logic                  fe_ack_o,
    output logic [width-1:0]      fe_rdata_o,

    // Memory port.
    output logic                  mem_req_o,
    output mem_op_t               mem_op_o,
    output logic [line_tag_w-1:0] mem_addr_o,
    output logic [width-1:0]      mem_wdata_o,
    input  logic                  mem_ack_i,
    input  logic [width-1:0]      mem_rdata_i
);

    arb_state_t state;

    logic last_fe;   // Last grant went to the fetch client.
    logic gnt_dr;
    logic gnt_fe;

    // ########################################################################
    // Grant FSM, held through all four phases.
    // ########################################################################
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= ARB_IDLE;
            last_fe <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Alternate when both ask.
                    if (dr_req_i && (!fe_req_i || last_fe)) begin
                        state   <= ARB_DRAIN;
                        last_fe <= 1'b0;
                    end else if (fe_req_i) begin
                        state   <= ARB_FETCH;
                        last_fe <= 1'b1;
                    end
                end
                ARB_DRAIN, ARB_FETCH: begin
                    if (mem_ack_i) state <= ARB_RELEASE;
                end
                ARB_RELEASE: begin
                    if (!mem_ack_i) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Release phase keeps the grant of the client that owned the cycle.
    assign gnt_dr = (state == ARB_DRAIN) || (state == ARB_RELEASE && !last_fe);
    assign gnt_fe = (state == ARB_FETCH) || (state == ARB_RELEASE && last_fe);

    // ########################################################################
    // Handshake forwarding.
    // ########################################################################
    assign mem_req_o   = (gnt_dr && dr_req_i) || (gnt_fe && fe_req_i);
    assign mem_op_o    = gnt_dr ? MEM_WRITE : MEM_READ;
    assign mem_addr_o  = gnt_dr ? dr_addr_i : fe_addr_i;
    assign mem_wdata_o = dr_data_i;

    assign dr_ack_o   = gnt_dr && mem_ack_i;
    assign fe_ack_o   = gnt_fe && mem_ack_i;
    assign fe_rdata_o = mem_rdata_i;

endmodule : mem_arbiter

/* source/ewb_subsystem.sv */
`timescale 1ns/1ps

module ewb_subsystem
    import rv32i_types::*;
#(
    parameter int width = 256,
    parameter int cap   = 64
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Evictions from the cache.
    input  logic                  evict_valid_i,
    input  logic [31:0]           evict_addr_i,
    input  logic [width-1:0]      evict_data_i,
    output logic                  evict_full_o,

    // Line refills to the cache.
    input  logic                  fill_req_i,
    input  logic [31:0]           fill_addr_i,
    output logic                  fill_ack_o,
    output logic [width-1:0]      fill_data_o,

    // Memory port.
    output logic                  mem_req_o,
    output mem_op_t               mem_op_o,
    output logic [line_tag_w-1:0] mem_addr_o,
    output logic [width-1:0]      mem_wdata_o,
    input  logic                  mem_ack_i,
    input  logic [width-1:0]      mem_rdata_i
);

    // ########################################################################
    // Internal nets.
    // ########################################################################
    logic                  tag_check;
    logic [line_tag_w-1:0] lookup_tag;
    logic                  hit;
    logic [width-1:0]      hit_data;

    logic                  empty;
    logic [31:0]           head_addr;
    logic [width-1:0]      head_data;
    logic                  yumi;

    logic                  dr_req;
    logic                  dr_ack;
    logic [line_tag_w-1:0] dr_addr;
    logic [width-1:0]      dr_data;

    logic                  fe_req;
    logic                  fe_ack;
    logic [line_tag_w-1:0] fe_addr;
    logic [width-1:0]      fe_rdata;

    ewb #(
        .width (width),
        .cap   (cap)
    ) ewb_i (
        .clk         (clk),
        .rst         (rst),
        .data_i      (evict_data_i),
        .addr_i      (evict_addr_i),
        .valid_i     (evict_valid_i),
        .full_o      (evict_full_o),
        .tag_check_i (tag_check),
        .tag_i       (lookup_tag),
        .hit_o       (hit),
        .read_o      (hit_data),
        .empty_o     (empty),
        .addr_o      (head_addr),
        .data_o      (head_data),
        .yumi_i      (yumi)
    );

    ewb_drain #(
        .width (width)
    ) ewb_drain_i (
        .clk         (clk),
        .rst         (rst),
        .empty_i     (empty),
        .head_addr_i (head_addr),
        .head_data_i (head_data),
        .yumi_o      (yumi),
        .wr_req_o    (dr_req),
        .wr_addr_o   (dr_addr),
        .wr_data_o   (dr_data),
        .wr_ack_i    (dr_ack)
    );

    line_fetch #(
        .width (width)
    ) line_fetch_i (
        .clk         (clk),
        .rst         (rst),
        .fill_req_i  (fill_req_i),
        .fill_addr_i (fill_addr_i),
        .fill_ack_o  (fill_ack_o),
        .fill_data_o (fill_data_o),
        .tag_check_o (tag_check),
        .tag_o       (lookup_tag),
        .hit_i       (hit),
        .hit_data_i  (hit_data),
        .rd_req_o    (fe_req),
        .rd_addr_o   (fe_addr),
        .rd_ack_i    (fe_ack),
        .rd_data_i   (fe_rdata)
    );

    mem_arbiter #(
        .width (width)
    ) mem_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .dr_req_i    (dr_req),
        .dr_addr_i   (dr_addr),
        .dr_data_i   (dr_data),
        .dr_ack_o    (dr_ack),
        .fe_req_i    (fe_req),
        .fe_addr_i   (fe_addr),
        .fe_ack_o    (fe_ack),
        .fe_rdata_o  (fe_rdata),
        .mem_req_o   (mem_req_o),
        .mem_op_o    (mem_op_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule : ewb_subsystem

/* testbench/mem_model.sv */
`timescale 1ns/1ps

module mem_model
    import rv32i_types::*;
#(
    parameter int width = 256
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req_i,
    input  mem_op_t               mem_op_i,
    input  logic [line_tag_w-1:0] mem_addr_i,
    input  logic [width-1:0]      mem_wdata_i,
    output logic                  mem_ack_o,
    output logic [width-1:0]      mem_rdata_o,
    input  logic                  stall_i,          // Holds ack low while set.
    output int                    write_count_o
);

    logic [width-1:0]      store [logic [line_tag_w-1:0]];
    logic [line_tag_w-1:0] log_tag[$];                // Writes in arrival order.
    logic [width-1:0]      log_data[$];
    int                    seed = 32'h15df_392b;
    int                    delay;
    logic                  busy;

    // Content of a line that was never written, one word per offset.
    function automatic logic [width-1:0] line_pattern(input logic [line_tag_w-1:0] tag);
        logic [width-1:0] line;
        for (int w = 0; w < width / 32; w++) begin
            line[w*32 +: 32] = {tag, 5'(w)} ^ 32'h3c96_a5f0;
        end
        return line;
    endfunction

    // ########################################################################
    // Four-phase responder with a random ack delay of 0 to 3 cycles.
    // ########################################################################
    always @(posedge clk, posedge rst) begin
        if (rst) begin
            mem_ack_o     <= 1'b0;
            mem_rdata_o   <= '0;
            busy          <= 1'b0;
            delay         <= 0;
            write_count_o <= 0;
        end else if (mem_ack_o) begin
            if (!mem_req_i) mem_ack_o <= 1'b0;      // Fourth phase.
        end else if (mem_req_i && !stall_i) begin
            if (!busy) begin
                busy  <= 1'b1;
                delay <= $unsigned($random(seed)) % 4;
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else begin
                busy      <= 1'b0;
                mem_ack_o <= 1'b1;
                if (mem_op_i == MEM_WRITE) begin
                    store[mem_addr_i] = mem_wdata_i;
                    log_tag.push_back(mem_addr_i);
                    log_data.push_back(mem_wdata_i);
                    write_count_o <= write_count_o + 1;
                end else if (store.exists(mem_addr_i)) begin
                    mem_rdata_o <= store[mem_addr_i];
                end else begin
                    mem_rdata_o <= line_pattern(mem_addr_i);
                end
            end
        end
    end

endmodule : mem_model

/* testbench/tb_ewb_subsystem.sv */
`timescale 1ns/1ps

module tb_ewb_subsystem
    import rv32i_types::*;
();

    localparam int width       = 256;
    localparam int cap         = 8;
    localparam int timeout     = 500;   // Cycles allowed for any single wait.
    localparam int hold        = 10;    // Cycles a held eviction is watched.
    localparam int hit_latency = 2;

    typedef enum {OP_EVICT, OP_FILL, OP_STALL_ON, OP_STALL_OFF, OP_DRAIN} step_op_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  evict_valid;
    logic [31:0]           evict_addr;
    logic [width-1:0]      evict_data;
    logic                  evict_full;
    logic                  fill_req;
    logic [31:0]           fill_addr;
    logic                  fill_ack;
    logic [width-1:0]      fill_data;
    logic                  mem_req;
    mem_op_t               mem_op;
    logic [line_tag_w-1:0] mem_addr;
    logic [width-1:0]      mem_wdata;
    logic                  mem_ack;
    logic [width-1:0]      mem_rdata;
    logic                  mem_stall;
    int                    mem_writes;

    // Stimulus table with one column per queue.
    step_op_t         op_q[$];
    logic [31:0]      addr_q[$];
    logic [width-1:0] data_q[$];
    logic             hit_q[$];     // Fill must be served by the buffer.

    // Reference model.
    logic [width-1:0]      ref_line [logic [line_tag_w-1:0]];
    logic [line_tag_w-1:0] exp_tag[$];
    logic [width-1:0]      exp_data[$];

    int          accepted;
    int          stall_base;
    int          errors;
    int          timeouts;
    logic        stalled;
    logic        held;
    logic        aborted;
    logic [31:0] held_addr;
    logic [width-1:0] held_data;

    always #10 clk = ~clk;

    ewb_subsystem #(.width(width), .cap(cap)) ewb_subsystem_i (
        .clk(clk), .rst(rst),
        .evict_valid_i(evict_valid), .evict_addr_i(evict_addr),
        .evict_data_i(evict_data), .evict_full_o(evict_full),
        .fill_req_i(fill_req), .fill_addr_i(fill_addr),
        .fill_ack_o(fill_ack), .fill_data_o(fill_data),
        .mem_req_o(mem_req), .mem_op_o(mem_op), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
    );

    mem_model #(.width(width)) mem_model_i (
        .clk(clk), .rst(rst),
        .mem_req_i(mem_req), .mem_op_i(mem_op), .mem_addr_i(mem_addr),
        .mem_wdata_i(mem_wdata), .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata),
        .stall_i(mem_stall), .write_count_o(mem_writes)
    );

    // ########################################################################
    // Line patterns.
    // ########################################################################
    function automatic logic [width-1:0] evict_line(input int n);
        logic [width-1:0] line;
        for (int w = 0; w < width / 32; w++) begin
            line[w*32 +: 32] = {8'(n), 8'(w), 16'hc0de};
        end
        return line;
    endfunction

    // Memory content before any write.
    function automatic logic [width-1:0] initial_line(input logic [line_tag_w-1:0] tag);
        logic [width-1:0] line;
        for (int w = 0; w < width / 32; w++) begin
            line[w*32 +: 32] = {tag, 5'(w)} ^ 32'h3c96_a5f0;
        end
        return line;
    endfunction

    task automatic add_step(input step_op_t op, input logic [31:0] addr,
                            input logic [width-1:0] data, input logic must_hit);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        hit_q.push_back(must_hit);
    endtask

    task automatic build_table();
        add_step(OP_FILL, 32'h0000_1000, '0, 1'b0);     // Miss path.
        // Same line twice behind a stall so the newest entry wins.
        add_step(OP_STALL_ON, '0, '0, 1'b0);
        add_step(OP_EVICT, 32'h0000_2000, evict_line(1), 1'b0);
        add_step(OP_EVICT, 32'h0000_2014, evict_line(2), 1'b0);
        add_step(OP_FILL, 32'h0000_2008, '0, 1'b1);
        add_step(OP_STALL_OFF, '0, '0, 1'b0);
        add_step(OP_DRAIN, '0, '0, 1'b0);
        // Fill the buffer behind a stall and hold a ninth eviction.
        add_step(OP_STALL_ON, '0, '0, 1'b0);
        for (int i = 0; i < cap; i++) begin
            add_step(OP_EVICT, 32'h0000_3000 + i * 32, evict_line(10 + i), 1'b0);
        end
        add_step(OP_FILL, 32'h0000_3044, '0, 1'b1);     // Hit during the stall.
        add_step(OP_EVICT, 32'h0000_3000, evict_line(30), 1'b0);
        add_step(OP_STALL_OFF, '0, '0, 1'b0);
        add_step(OP_DRAIN, '0, '0, 1'b0);
        for (int i = 0; i < cap; i++) begin
            add_step(OP_FILL, 32'h0000_3000 + i * 32, '0, 1'b0);
        end
        add_step(OP_FILL, 32'h0000_2000, '0, 1'b0);
        // Evictions back to back while the drain retires entries.
        for (int i = 0; i < 12; i++) begin
            add_step(OP_EVICT, 32'h0000_4000 + (i % 5) * 32, evict_line(40 + i), 1'b0);
        end
        add_step(OP_DRAIN, '0, '0, 1'b0);
        for (int i = 0; i < 5; i++) begin
            add_step(OP_FILL, 32'h0000_4000 + i * 32, '0, 1'b0);
        end
    endtask

    task automatic timed_out(input string what);
        $display("ERROR: timeout at time %0t while waiting for %s", $time, what);
        timeouts++;
        aborted = 1'b1;
    endtask

    // ########################################################################
    // Port drivers.
    // ########################################################################
    task automatic accept_evict(input logic [31:0] addr, input logic [width-1:0] data);
        int   n;
        logic free;
        n    = 0;
        free = 1'b0;
        while (!free && n < timeout) begin
            @(negedge clk);
            free = !evict_full;                       // Taken at the next edge.
            n++;
        end
        if (!free) begin
            timed_out("an eviction to be accepted");
        end else begin
            @(posedge clk);
            evict_valid <= 1'b0;
            ref_line[addr[31:line_off_w]] = data;
            exp_tag.push_back(addr[31:line_off_w]);
            exp_data.push_back(data);
            accepted++;
        end
    endtask

    task automatic evict(input logic [31:0] addr, input logic [width-1:0] data);
        @(posedge clk);
        evict_valid <= 1'b1;
        evict_addr  <= addr;
        evict_data  <= data;
        if (stalled && (accepted - stall_base) >= cap) begin
            // Buffer full behind the stall.
            for (int c = 0; c < hold; c++) begin
                @(negedge clk);
                if (!evict_full) begin
                    $display("CHECK FAILED at time %0t: evict_full_o low with %0d entries held",
                             $time, accepted - stall_base);
                    errors++;
                end
            end
            held      = 1'b1;
            held_addr = addr;
            held_data = data;
        end else begin
            accept_evict(addr, data);
        end
    endtask

    task automatic fill(input logic [31:0] addr, input logic must_hit);
        logic [line_tag_w-1:0] tag;
        logic [width-1:0]      expected;
        int                    n;
        tag      = addr[31:line_off_w];
        expected = ref_line.exists(tag) ? ref_line[tag] : initial_line(tag);
        @(posedge clk);
        fill_req  <= 1'b1;
        fill_addr <= addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!fill_ack && n < timeout);
        if (!fill_ack) begin
            timed_out("the fill acknowledge");
        end else begin
            if (fill_data !== expected) begin
                $display("CHECK FAILED at time %0t: fill of %h returned %h, expected %h",
                         $time, addr, fill_data, expected);
                errors++;
            end
            // First negedge lies before the edge that samples the request.
            if (must_hit && (n - 2) != hit_latency) begin
                $display("CHECK FAILED at time %0t: hit on %h took %0d cycles, expected %0d",
                         $time, addr, n - 2, hit_latency);
                errors++;
            end
            @(posedge clk);
            fill_req <= 1'b0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (fill_ack && n < timeout);
            if (fill_ack) timed_out("the fill acknowledge to drop");
        end
    endtask

    task automatic drain_wait();
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < timeout) begin
            @(negedge clk);
            done = (mem_writes == accepted) && !mem_req && !mem_ack;
            n++;
        end
        if (!done) begin
            timed_out("the buffer to drain");
        end else begin
            @(posedge clk);                           // Last entry retires here.
        end
    endtask

    task automatic check_log();
        if (mem_writes != accepted) begin
            $display("CHECK FAILED at time %0t: %0d writes logged, %0d evictions accepted",
                     $time, mem_writes, accepted);
            errors++;
        end
        for (int i = 0; i < accepted && i < mem_writes; i++) begin
            if (mem_model_i.log_tag[i] !== exp_tag[i]) begin
                $display("CHECK FAILED at time %0t: write %0d went to line %h, expected %h",
                         $time, i, mem_model_i.log_tag[i], exp_tag[i]);
                errors++;
            end
            if (mem_model_i.log_data[i] !== exp_data[i]) begin
                $display("CHECK FAILED at time %0t: write %0d carried %h, expected %h",
                         $time, i, mem_model_i.log_data[i], exp_data[i]);
                errors++;
            end
        end
    endtask

    // ########################################################################
    // Main sequence.
    // ########################################################################
    initial begin
        rst         = 1'b1;
        evict_valid = 1'b0;
        evict_addr  = '0;
        evict_data  = '0;
        fill_req    = 1'b0;
        fill_addr   = '0;
        mem_stall   = 1'b0;
        accepted    = 0;
        stall_base  = 0;
        errors      = 0;
        timeouts    = 0;
        stalled     = 1'b0;
        held        = 1'b0;
        aborted     = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (evict_full || fill_ack || mem_req) begin
            $display("CHECK FAILED at time %0t: after reset full=%b fill_ack=%b mem_req=%b",
                     $time, evict_full, fill_ack, mem_req);
            errors++;
        end
        for (int s = 0; s < op_q.size() && !aborted; s++) begin
            case (op_q[s])
                OP_EVICT: evict(addr_q[s], data_q[s]);
                OP_FILL:  fill(addr_q[s], hit_q[s]);
                OP_STALL_ON: begin
                    @(posedge clk);
                    mem_stall <= 1'b1;
                    stalled    = 1'b1;
                    stall_base = accepted;
                end
                OP_STALL_OFF: begin
                    @(posedge clk);
                    mem_stall <= 1'b0;
                    stalled = 1'b0;
                    if (held) begin
                        held = 1'b0;
                        accept_evict(held_addr, held_data);
                    end
                end
                default: drain_wait();
            endcase
        end
        if (!aborted) check_log();
        $display("Summary: %0d steps, %0d evictions accepted, %0d check errors, %0d timeouts",
                 op_q.size(), accepted, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_ewb_subsystem

/* list.f */
source/rv32i_types.sv
source/ewb.sv
source/ewb_drain.sv
source/line_fetch.sv
source/mem_arbiter.sv
source/ewb_subsystem.sv
testbench/mem_model.sv
testbench/tb_ewb_subsystem.sv

/* Makefile */
# Verilator flow for the eviction write buffer subsystem.
# Any variable below can be overridden on the command line.

VERILATOR   ?= verilator
FILELIST    ?= list.f
TB_TOP      ?= tb_ewb_subsystem
RTL_TOP     ?= ewb_subsystem
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary -j 0
LINT_FLAGS  ?= -Wall
PASS_MSG    ?= TB PASSED

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass line shows up in the simulator output.
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
